// File: logic/hps_params.svh
`ifndef HPS_PARAMS_SVH
`define HPS_PARAMS_SVH

// host bus word and command word counter
`define HPS_WORD_W 16
`define HPS_CNT_W 6

// command codes on io_enable frames
`define CMD_CFG 16'h0001
`define CMD_JOY0 16'h0002
`define CMD_JOY1 16'h0003
`define CMD_CONF_STR 16'h0014
`define CMD_STATUS 16'h001E

// command codes on fp_enable frames
`define FIO_FILE_TX 16'h0053
`define FIO_FILE_TX_DAT 16'h0054
`define FIO_FILE_INDEX 16'h0055

// core configuration string, first character goes out first
`define CONF_STR "CORE;;O1,Fast;V1"
`define CONF_STRLEN 16

`define IOCTL_ADDR_W 27

`endif

// File: logic/hps_pkg.sv
`include "hps_params.svh"

package hps_pkg;

	typedef logic [`HPS_WORD_W-1:0] io_word_t;
	typedef logic [31:0] joy_t;
	typedef logic [63:0] status_t;
	typedef logic [15:0] cfg_t;
	typedef logic [`IOCTL_ADDR_W-1:0] ioctl_addr_t;
	typedef logic [7:0] ioctl_data_t;

	// host side of the bus, as seen by the core
	typedef struct packed {
		logic io_enable;
		logic fp_enable;
		logic io_strobe;
		io_word_t io_din;
	} host_bus_t;

	// download port towards the core
	typedef struct packed {
		logic download;
		logic [15:0] index;
		logic wr;
		ioctl_addr_t addr;
		ioctl_data_t dout;
	} ioctl_bus_t;

	// decoder frame phase
	typedef enum logic [1:0] {
		UIO_IDLE,
		UIO_CMD,
		UIO_DATA
	} uio_phase_t;

endpackage

// File: logic/conf_rom.sv
`timescale 1ns/1ns
`include "hps_params.svh"

module conf_rom (
	input  logic                  clk_sys,
	input  logic [`HPS_CNT_W-1:0] addr,
	output logic [7:0]            conf_byte
);

	localparam int DEPTH = 1 << `HPS_CNT_W;
	localparam logic [8*`CONF_STRLEN-1:0] CONF_BITS = `CONF_STR;

	logic [7:0] rom [DEPTH];

	// string literal keeps its first character in the top byte
	initial begin
		for (int i = 0; i < DEPTH; i++) begin
			if (i < `CONF_STRLEN)
				rom[i] = CONF_BITS[8*(`CONF_STRLEN-i)-1 -: 8];
			else
				rom[i] = 8'h00;
		end
	end

	// read register for block ram
	always_ff @(posedge clk_sys) begin
		conf_byte <= rom[addr];
	end

endmodule

// File: logic/uio_decoder.sv
`timescale 1ns/1ns
`include "hps_params.svh"

module uio_decoder (
	input  logic               clk_sys,
	input  logic               rst_n,
	input  hps_pkg::host_bus_t host,
	output hps_pkg::io_word_t  io_dout,

	output logic [1:0]         buttons,
	output logic               forced_scandoubler,
	output logic               direct_video,
	output hps_pkg::joy_t      joystick_0,
	output hps_pkg::joy_t      joystick_1,
	output hps_pkg::status_t   status
);

	hps_pkg::uio_phase_t   phase;
	hps_pkg::io_word_t     cmd;
	// data words seen since the command, saturating
	logic [`HPS_CNT_W-1:0] cnt;
	hps_pkg::cfg_t         cfg;
	logic [7:0]            conf_byte;
	logic                  data_stb;

	// one half of a joystick word, picked by the word count
	function automatic hps_pkg::joy_t joy_fill(input hps_pkg::joy_t cur, input logic high,
		input hps_pkg::io_word_t word);
		hps_pkg::joy_t nxt;
		nxt = cur;
		if (high)
			nxt[31:16] = word;
		else
			nxt[15:0] = word;
		return nxt;
	endfunction

	//////////////////////////////////////////////////
	// frame tracking
	//////////////////////////////////////////////////

	assign data_stb = host.io_enable & host.io_strobe & (phase == hps_pkg::UIO_DATA);

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			phase <= hps_pkg::UIO_IDLE;
			cmd <= '0;
			cnt <= '0;
			io_dout <= '0;
		end else if (!host.io_enable) begin
			phase <= hps_pkg::UIO_IDLE;
			cmd <= '0;
			cnt <= '0;
			io_dout <= '0;
		end else if (host.io_strobe) begin
			io_dout <= '0;
			if (phase != hps_pkg::UIO_DATA) begin
				// first word of the frame
				cmd <= host.io_din;
				cnt <= '0;
				phase <= hps_pkg::UIO_DATA;
			end else begin
				if (~&cnt)
					cnt <= cnt + 1'b1;
				if (cmd == `CMD_CONF_STR)
					io_dout <= {8'h00, conf_byte};
			end
		end else if (phase == hps_pkg::UIO_IDLE) begin
			phase <= hps_pkg::UIO_CMD;
		end
	end

	// rom is addressed by the data word count, so byte k-1 waits at strobe k
	conf_rom conf_rom_i (
		.clk_sys   (clk_sys),
		.addr      (cnt),
		.conf_byte (conf_byte)
	);

	//////////////////////////////////////////////////
	// core registers
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			cfg <= '0;
			joystick_0 <= '0;
			joystick_1 <= '0;
			status <= '0;
		end else if (data_stb) begin
			case (cmd)
				`CMD_CFG: begin
					cfg <= host.io_din;
				end
				`CMD_JOY0: begin
					joystick_0 <= joy_fill(joystick_0, cnt != '0, host.io_din);
				end
				`CMD_JOY1: begin
					joystick_1 <= joy_fill(joystick_1, cnt != '0, host.io_din);
				end
				`CMD_STATUS: begin
					// four quarters, lowest first
					if (cnt[`HPS_CNT_W-1:2] == '0)
						status[{cnt[1:0], 4'b0000} +: 16] <= host.io_din;
				end
				default: begin
				end
			endcase
		end
	end

	// bits 2, 3 and 5 are handled outside the core
	assign buttons = cfg[1:0];
	assign forced_scandoubler = cfg[4];
	assign direct_video = cfg[10];

endmodule

// File: logic/file_loader.sv
`timescale 1ns/1ns
`include "hps_params.svh"

module file_loader (
	input  logic                clk_sys,
	input  logic                rst_n,
	input  hps_pkg::host_bus_t  host,
	output hps_pkg::io_word_t   io_dout,
	output hps_pkg::ioctl_bus_t ioctl
);

	logic                 has_cmd;
	hps_pkg::io_word_t    cmd;
	// argument words after the command, saturating
	logic [1:0]           arg_cnt;
	hps_pkg::ioctl_addr_t next_addr;
	logic                 wr_pend;
	logic                 arg_stb;

	logic                 download;
	hps_pkg::io_word_t    index;
	logic                 wr;
	hps_pkg::ioctl_addr_t addr;
	hps_pkg::ioctl_data_t dout;

	assign arg_stb = host.fp_enable & host.io_strobe & has_cmd;

	//////////////////////////////////////////////////
	// file command framing
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			has_cmd <= 1'b0;
			cmd <= '0;
			arg_cnt <= '0;
		end else if (!host.fp_enable) begin
			has_cmd <= 1'b0;
		end else if (host.io_strobe) begin
			if (!has_cmd) begin
				has_cmd <= 1'b1;
				cmd <= host.io_din;
				arg_cnt <= '0;
			end else if (~&arg_cnt) begin
				arg_cnt <= arg_cnt + 1'b1;
			end
		end
	end

	// download flag and write pulse
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			download <= 1'b0;
			wr_pend <= 1'b0;
			wr <= 1'b0;
		end else begin
			wr <= wr_pend;
			wr_pend <= arg_stb & (cmd == `FIO_FILE_TX_DAT) & download;
			if (arg_stb && cmd == `FIO_FILE_TX && arg_cnt == 2'd0)
				download <= |host.io_din;
		end
	end

	//////////////////////////////////////////////////
	// index, address and data
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (arg_stb) begin
			case (cmd)
				`FIO_FILE_INDEX: begin
					index <= host.io_din;
				end
				`FIO_FILE_TX: begin
					case (arg_cnt)
						2'd0: begin
							if (|host.io_din)
								next_addr <= '0;
							else if (download)
								addr <= next_addr;
						end
						2'd1: begin
							addr[15:0] <= host.io_din;
							next_addr[15:0] <= host.io_din;
						end
						2'd2: begin
							addr[`IOCTL_ADDR_W-1:16] <= host.io_din[`IOCTL_ADDR_W-17:0];
							next_addr[`IOCTL_ADDR_W-1:16] <= host.io_din[`IOCTL_ADDR_W-17:0];
						end
						default: begin
						end
					endcase
				end
				`FIO_FILE_TX_DAT: begin
					// addr and dout settle a cycle before wr
					if (download) begin
						addr <= next_addr;
						dout <= host.io_din[7:0];
						next_addr <= next_addr + 1'b1;
					end
				end
				default: begin
				end
			endcase
		end
	end

	// no upload path, nothing to read back
	assign io_dout = '0;

	assign ioctl.download = download;
	assign ioctl.index = index;
	assign ioctl.wr = wr;
	assign ioctl.addr = addr;
	assign ioctl.dout = dout;

endmodule

// File: logic/hps_io.sv
`timescale 1ns/1ns

module hps_io (
	input  logic                clk_sys,
	input  logic                rst_n,
	input  hps_pkg::host_bus_t  host,
	output hps_pkg::io_word_t   io_dout,

	output logic [1:0]          buttons,
	output logic                forced_scandoubler,
	output logic                direct_video,
	output hps_pkg::joy_t       joystick_0,
	output hps_pkg::joy_t       joystick_1,
	output hps_pkg::status_t    status,

	output hps_pkg::ioctl_bus_t ioctl
);

	hps_pkg::io_word_t uio_dout;
	hps_pkg::io_word_t fp_dout;

	//////////////////////////////////////////////////
	// command frames on io_enable
	//////////////////////////////////////////////////

	uio_decoder uio_decoder_i (
		.clk_sys            (clk_sys),
		.rst_n              (rst_n),
		.host               (host),
		.io_dout            (uio_dout),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.direct_video       (direct_video),
		.joystick_0         (joystick_0),
		.joystick_1         (joystick_1),
		.status             (status)
	);

	//////////////////////////////////////////////////
	// file frames on fp_enable
	//////////////////////////////////////////////////

	file_loader file_loader_i (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.host    (host),
		.io_dout (fp_dout),
		.ioctl   (ioctl)
	);

	// read word back to the host
	assign io_dout = host.fp_enable ? fp_dout : uio_dout;

endmodule

// File: sim/hps_io_checker.sv
`timescale 1ns/1ns

module hps_io_checker (
	input logic                clk_sys,
	input logic                rst_n,
	input hps_pkg::status_t    status,
	input hps_pkg::ioctl_bus_t ioctl
);

	hps_pkg::ioctl_addr_t last_addr;
	logic                 have_last;

	// address of the previous write in this download
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			last_addr <= '0;
			have_last <= 1'b0;
		end else if (!ioctl.download) begin
			have_last <= 1'b0;
		end else if (ioctl.wr) begin
			last_addr <= ioctl.addr;
			have_last <= 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// download port
	//////////////////////////////////////////////////

	wr_in_download: assert property (@(posedge clk_sys) disable iff (!rst_n)
		ioctl.wr |-> ioctl.download)
		else $error("ioctl wr while download is low");

	wr_single_cycle: assert property (@(posedge clk_sys) disable iff (!rst_n)
		ioctl.wr |=> !ioctl.wr)
		else $error("ioctl wr longer than one cycle");

	wr_addr_step: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(ioctl.wr && have_last) |-> (ioctl.addr == last_addr + 1'b1))
		else $error("ioctl addr did not advance by one between writes");

	// outputs cleared by the synchronous reset
	reset_values: assert property (@(posedge clk_sys)
		!rst_n |=> (!ioctl.download && !ioctl.wr && status == '0))
		else $error("download, wr or status not cleared in reset");

endmodule

bind hps_io hps_io_checker hps_io_checker_i (
	.clk_sys (clk_sys),
	.rst_n   (rst_n),
	.status  (status),
	.ioctl   (ioctl)
);

// File: sim/hps_io_tb.sv
`timescale 1ns/1ns
`include "hps_params.svh"

module hps_io_tb;

	localparam int TIMEOUT_CYCLES = 4000;
	localparam int N_BYTES = 20;
	localparam int N_ROUNDS = 4;
	localparam hps_pkg::ioctl_addr_t START_ADDR = 27'h1234560;

	logic                clk_sys;
	logic                rst_n;
	hps_pkg::host_bus_t  host;
	hps_pkg::io_word_t   io_dout;
	logic [1:0]          buttons;
	logic                forced_scandoubler;
	logic                direct_video;
	hps_pkg::joy_t       joystick_0;
	hps_pkg::joy_t       joystick_1;
	hps_pkg::status_t    status;
	hps_pkg::ioctl_bus_t ioctl;

	integer               seed;
	int                   cycles = 0;
	int                   wr_seen;
	hps_pkg::ioctl_data_t exp_data [N_BYTES];
	hps_pkg::io_word_t    dl_words [N_BYTES];
	string                conf_text;

	hps_io hps_io_i (
		.clk_sys            (clk_sys),
		.rst_n              (rst_n),
		.host               (host),
		.io_dout            (io_dout),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.direct_video       (direct_video),
		.joystick_0         (joystick_0),
		.joystick_1         (joystick_1),
		.status             (status),
		.ioctl              (ioctl)
	);

	initial clk_sys = 1'b0;
	always #50 clk_sys = ~clk_sys;

	// run limit
	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout, the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("*** TEST FAILED ***");
			$fatal(1, "timeout");
		end
	end

	//////////////////////////////////////////////////
	// checks and host bus tasks
	//////////////////////////////////////////////////

	task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		assert (actual === expected) else begin
			$display("FAILED %s: expected %h, actual %h", name, expected, actual);
			$display("*** TEST FAILED ***");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		assert (cond === 1'b1) else begin
			$display("%s", what);
			$display("*** TEST FAILED ***");
			$fatal(1, "check failed");
		end
	endtask

	function automatic hps_pkg::io_word_t next_word();
		logic [31:0] r;
		r = $random(seed);
		return r[15:0];
	endfunction

	// called on a falling edge and returns on one
	task automatic start_frame(input logic fp);
		host.io_enable = ~fp;
		host.fp_enable = fp;
		@(negedge clk_sys);
	endtask

	task automatic send_word(input hps_pkg::io_word_t word);
		host.io_strobe = 1'b1;
		host.io_din = word;
		@(negedge clk_sys);
		host.io_strobe = 1'b0;
		repeat (2) @(negedge clk_sys);
	endtask

	task automatic end_frame();
		host.io_enable = 1'b0;
		host.fp_enable = 1'b0;
		host.io_din = '0;
		repeat (2) @(negedge clk_sys);
	endtask

	task automatic cfg_test(input hps_pkg::io_word_t word);
		start_frame(1'b0);
		send_word(`CMD_CFG);
		send_word(word);
		end_frame();
		check_value("cfg buttons", 64'(word[1:0]), 64'(buttons));
		check_value("cfg forced_scandoubler", 64'(word[4]), 64'(forced_scandoubler));
		check_value("cfg direct_video", 64'(word[10]), 64'(direct_video));
	endtask

	// each write pulse against the next expected byte
	always @(negedge clk_sys) begin
		if (ioctl.wr === 1'b1) begin
			check_true(wr_seen < N_BYTES, "write pulse seen after all download bytes");
			check_value("download addr", 64'(START_ADDR + wr_seen), 64'(ioctl.addr));
			check_value("download data", 64'(exp_data[wr_seen]), 64'(ioctl.dout));
			wr_seen = wr_seen + 1;
		end
	end

	//////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////

	initial begin
		hps_pkg::io_word_t words [4];
		logic [7:0] exp_byte;
		seed = 82915;
		conf_text = `CONF_STR;
		host = '0;
		rst_n = 1'b0;
		wr_seen = 0;
		repeat (4) @(negedge clk_sys);
		rst_n = 1'b1;
		@(negedge clk_sys);

		check_value("reset status", 64'(0), status);
		check_value("reset joystick_0", 64'(0), 64'(joystick_0));
		check_value("reset joystick_1", 64'(0), 64'(joystick_1));
		check_value("reset buttons", 64'(0), 64'(buttons));
		check_value("reset download", 64'(0), 64'(ioctl.download));
		check_value("reset wr", 64'(0), 64'(ioctl.wr));

		cfg_test(16'h0413);
		cfg_test(16'hFBEC);

		for (int r = 0; r < N_ROUNDS; r++) begin
			for (int i = 0; i < 4; i++)
				words[i] = next_word();
			start_frame(1'b0);
			send_word(`CMD_JOY0);
			send_word(words[0]);
			send_word(words[1]);
			end_frame();
			check_value("joystick_0", 64'({words[1], words[0]}), 64'(joystick_0));
			start_frame(1'b0);
			send_word(`CMD_JOY1);
			send_word(words[2]);
			send_word(words[3]);
			end_frame();
			check_value("joystick_1", 64'({words[3], words[2]}), 64'(joystick_1));
			for (int i = 0; i < 4; i++)
				words[i] = next_word();
			start_frame(1'b0);
			send_word(`CMD_STATUS);
			for (int i = 0; i < 4; i++)
				send_word(words[i]);
			end_frame();
			check_value("status", {words[3], words[2], words[1], words[0]}, status);
		end

		// string bytes in order and then zeros past the end
		start_frame(1'b0);
		send_word(`CMD_CONF_STR);
		for (int k = 1; k <= `CONF_STRLEN + 2; k++) begin
			send_word(16'h0000);
			exp_byte = (k <= `CONF_STRLEN) ? conf_text[k-1] : 8'h00;
			check_value("conf string byte", 64'(exp_byte), 64'(io_dout));
		end
		end_frame();

		// frame left with a string byte on io_dout
		start_frame(1'b0);
		send_word(`CMD_CONF_STR);
		send_word(16'h0000);
		end_frame();
		check_value("io_dout after frame", 64'(0), 64'(io_dout));

		start_frame(1'b1);
		send_word(`FIO_FILE_INDEX);
		send_word(16'h0002);
		end_frame();
		check_value("file index", 64'(16'h0002), 64'(ioctl.index));

		start_frame(1'b1);
		send_word(`FIO_FILE_TX);
		send_word(16'h00FF);
		send_word(START_ADDR[15:0]);
		send_word({5'b00000, START_ADDR[`IOCTL_ADDR_W-1:16]});
		end_frame();
		check_value("download start", 64'(1), 64'(ioctl.download));

		for (int i = 0; i < N_BYTES; i++) begin
			dl_words[i] = next_word();
			exp_data[i] = dl_words[i][7:0];
		end
		start_frame(1'b1);
		send_word(`FIO_FILE_TX_DAT);
		for (int i = 0; i < N_BYTES; i++)
			send_word(dl_words[i]);
		end_frame();
		check_value("write pulse count", 64'(N_BYTES), 64'(wr_seen));

		start_frame(1'b1);
		send_word(`FIO_FILE_TX);
		send_word(16'h0000);
		end_frame();
		repeat (4) @(negedge clk_sys);
		check_value("download stop", 64'(0), 64'(ioctl.download));

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

// File: files.f
+incdir+logic
logic/hps_pkg.sv
logic/conf_rom.sv
logic/uio_decoder.sv
logic/file_loader.sv
logic/hps_io.sv
sim/hps_io_checker.sv
sim/hps_io_tb.sv

// File: Makefile
TOP = hps_io_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f files.f -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
